/* list.f */
hw/cipher_pkg.sv
hw/accel_ctrl_pkg.sv
hw/mem_stream_if.sv
hw/accel_regfile.sv
hw/block_fsm.sv
hw/word_streamer.sv
hw/xtea_engine.sv
hw/cipher_accel_top.sv
bench/accel_checker.sv
bench/tb_cipher_accel.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, exit status is the verdict
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_cipher_accel -f list.f
./obj_dir/Vtb_cipher_accel

/* bench/tb_cipher_accel.sv */
`timescale 1ns/10ps

module tb_cipher_accel;
  import accel_ctrl_pkg::*;
  import cipher_pkg::*;

  localparam int NUM_JOBS    = 5;
  localparam int JOB_CYCLES  = 200;
  localparam int CLK_PERIOD  = 20;
  localparam int WATCHDOG_NS = NUM_JOBS * JOB_CYCLES * CLK_PERIOD;

  logic                  clk;
  logic                  reset_n;
  logic [REG_ADDR_W-1:0] s_awaddr_i;
  logic                  s_awvalid_i;
  logic                  s_awready_o;
  word_t                 s_wdata_i;
  logic                  s_wvalid_i;
  logic                  s_wready_o;
  logic                  s_bvalid_o;
  logic                  s_bready_i;
  logic [REG_ADDR_W-1:0] s_araddr_i;
  logic                  s_arvalid_i;
  logic                  s_arready_o;
  word_t                 s_rdata_o;
  logic                  s_rvalid_o;
  logic                  s_rready_i;
  logic                  mem_req_o;
  logic                  mem_we_o;
  logic [ADDR_W-1:0]     mem_addr_o;
  word_t                 mem_wdata_o;
  logic                  mem_gnt_i    = 1'b0;
  logic                  mem_rvalid_i = 1'b0;
  word_t                 mem_rdata_i  = '0;
  logic                  done_o;

  // Memory model state
  word_t  mem_model [logic [ADDR_W-1:0]];
  integer seed         = 87;
  int     stall_left   = 0;
  logic   read_pending = 1'b0;
  word_t  read_data    = '0;
  int     write_count  = 0;
  int     done_count   = 0;

  cipher_accel_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired: the jobs did not finish in the expected time");
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog timeout");
  end

  // Unwritten locations read back an address-derived pattern
  function automatic word_t mem_read(input logic [ADDR_W-1:0] addr);
    if (mem_model.exists(addr))
      return mem_model[addr];
    return addr ^ 32'h5A5A_C3C3;
  endfunction

  // Grant after 0 to 3 idle cycles, read data one cycle after grant
  always @(posedge clk) begin
    mem_gnt_i    <= 1'b0;
    mem_rvalid_i <= 1'b0;
    if (read_pending) begin
      mem_rvalid_i <= 1'b1;
      mem_rdata_i  <= read_data;
      read_pending = 1'b0;
    end
    if (reset_n && mem_req_o && !mem_gnt_i) begin
      if (stall_left > 0) begin
        stall_left--;
      end else begin
        mem_gnt_i <= 1'b1;
        if (mem_we_o) begin
          mem_model[mem_addr_o] = mem_wdata_o;
          write_count++;
        end else begin
          read_data    = mem_read(mem_addr_o);
          read_pending = 1'b1;
        end
        stall_left = $random(seed) & 3;
      end
    end
  end

  always @(posedge clk) begin
    if (reset_n && done_o)
      done_count++;
  end

  // Standard XTEA encryption of one 64-bit lane, v0 in the low word
  function automatic logic [63:0] xtea_lane(input logic [63:0] lane, input key_t key);
    word_t v0;
    word_t v1;
    word_t sum;
    v0  = lane[31:0];
    v1  = lane[63:32];
    sum = '0;
    for (int r = 0; r < XTEA_ROUNDS; r++) begin
      v0  += (((v1 << 4) ^ (v1 >> 5)) + v1) ^ (sum + key[sum[1:0]]);
      sum += XTEA_DELTA;
      v1  += (((v0 << 4) ^ (v0 >> 5)) + v0) ^ (sum + key[sum[12:11]]);
    end
    return {v1, v0};
  endfunction

  task automatic check_word(input word_t got, input word_t expected, input string what);
    assert (got === expected) else begin
      $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
      $display("SOME TESTS FAILED");
      $fatal(1, "check failed");
    end
  endtask

  task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input word_t data);
    @(posedge clk);
    s_awaddr_i  <= addr;
    s_awvalid_i <= 1'b1;
    s_wdata_i   <= data;
    s_wvalid_i  <= 1'b1;
    s_bready_i  <= 1'b1;
    @(posedge clk);
    while (!s_awready_o)
      @(posedge clk);
    // AW and W are taken in the same cycle
    check_word(word_t'(s_wready_o), 32'd1, "W channel accepted together with AW");
    s_awvalid_i <= 1'b0;
    s_wvalid_i  <= 1'b0;
    @(posedge clk);
    while (!s_bvalid_o)
      @(posedge clk);
    s_bready_i <= 1'b0;
  endtask

  task automatic read_reg(input logic [REG_ADDR_W-1:0] addr, output word_t data);
    @(posedge clk);
    s_araddr_i  <= addr;
    s_arvalid_i <= 1'b1;
    s_rready_i  <= 1'b1;
    @(posedge clk);
    while (!s_arready_o)
      @(posedge clk);
    s_arvalid_i <= 1'b0;
    @(posedge clk);
    while (!s_rvalid_o)
      @(posedge clk);
    data = s_rdata_o;
    s_rready_i <= 1'b0;
  endtask

  // One job with fresh addresses, key and plaintext
  task automatic run_job(input int job);
    logic [ADDR_W-1:0] src;
    logic [ADDR_W-1:0] dst;
    key_t              key;
    block_u            plain;
    block_u            expected;
    word_t             got;
    int                writes_before;
    int                dones_before;
    src = 32'h1000_0000 | ($random(seed) & 32'h000F_FFF0);
    dst = 32'h2000_0000 | ($random(seed) & 32'h000F_FFF0);
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      key[i]         = $random(seed);
      plain.words[i] = $random(seed);
      mem_model[src + ADDR_W'(4 * i)] = plain.words[i];
    end
    for (int l = 0; l < 2; l++)
      expected.halves[l] = xtea_lane(plain.halves[l], key);

    write_reg(REG_SRC, src);
    write_reg(REG_DST, dst);
    for (int i = 0; i < 4; i++)
      write_reg(REG_ADDR_W'(REG_KEY0 + 4 * i), key[i]);
    read_reg(REG_SRC, got);
    check_word(got, src, $sformatf("job %0d SRC readback", job));
    read_reg(REG_DST, got);
    check_word(got, dst, $sformatf("job %0d DST readback", job));
    for (int i = 0; i < 4; i++) begin
      read_reg(REG_ADDR_W'(REG_KEY0 + 4 * i), got);
      check_word(got, key[i], $sformatf("job %0d KEY%0d readback", job, i));
    end

    writes_before = write_count;
    dones_before  = done_count;
    write_reg(REG_CTRL, 32'h1);
    // Busy set and the previous done cleared
    read_reg(REG_STATUS, got);
    check_word(got, 32'h1, $sformatf("job %0d STATUS while busy", job));
    write_reg(REG_CTRL, 32'h1);
    @(posedge clk);
    while (!done_o)
      @(posedge clk);
    read_reg(REG_STATUS, got);
    check_word(got, 32'h2, $sformatf("job %0d STATUS after done", job));
    check_word(word_t'(write_count - writes_before), 32'd4,
               $sformatf("job %0d memory write count", job));
    check_word(word_t'(done_count - dones_before), 32'd1,
               $sformatf("job %0d done pulse count", job));
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      check_word(mem_read(dst + ADDR_W'(4 * i)), expected.words[i],
                 $sformatf("job %0d ciphertext word %0d", job, i));
      check_word(mem_read(src + ADDR_W'(4 * i)), plain.words[i],
                 $sformatf("job %0d source word %0d", job, i));
    end
  endtask

  initial begin
    word_t status;
    reset_n     = 1'b0;
    s_awaddr_i  = '0;
    s_awvalid_i = 1'b0;
    s_wdata_i   = '0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b0;
    s_araddr_i  = '0;
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b0;
    repeat (3) @(posedge clk);
    reset_n <= 1'b1;
    @(posedge clk);

    read_reg(REG_STATUS, status);
    check_word(status, 32'h0, "STATUS after reset");
    for (int j = 0; j < NUM_JOBS; j++)
      run_job(j);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* bench/accel_checker.sv */
`timescale 1ns/10ps

module accel_checker (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic                              mem_req_i,
  input  logic                              mem_we_i,
  input  logic [accel_ctrl_pkg::ADDR_W-1:0] mem_addr_i,
  input  cipher_pkg::word_t                 mem_wdata_i,
  input  logic                              mem_gnt_i,
  input  logic                              s_bvalid_i,
  input  logic                              s_bready_i,
  input  logic                              done_i
);

  // Request and its payload frozen while waiting for grant
  req_held: assert property (
    @(posedge clk) disable iff (!reset_n)
    mem_req_i && !mem_gnt_i |=> mem_req_i && $stable(mem_we_i)
                                && $stable(mem_addr_i) && $stable(mem_wdata_i)
  ) else $error("memory request dropped or changed before grant");

  // Write response waits for the host
  bvalid_held: assert property (
    @(posedge clk) disable iff (!reset_n)
    s_bvalid_i && !s_bready_i |=> s_bvalid_i
  ) else $error("write response withdrawn before bready");

  done_pulse: assert property (
    @(posedge clk) disable iff (!reset_n)
    done_i |=> !done_i
  ) else $error("done pulse longer than one cycle");

endmodule

bind cipher_accel_top accel_checker u_checker (
  .clk         (clk),
  .reset_n     (reset_n),
  .mem_req_i   (mem_req_o),
  .mem_we_i    (mem_we_o),
  .mem_addr_i  (mem_addr_o),
  .mem_wdata_i (mem_wdata_o),
  .mem_gnt_i   (mem_gnt_i),
  .s_bvalid_i  (s_bvalid_o),
  .s_bready_i  (s_bready_i),
  .done_i      (done_o)
);

/* hw/cipher_accel_top.sv */
`timescale 1ns/10ps

module cipher_accel_top (
  input  logic                                  clk,
  input  logic                                  reset_n,
  input  logic [accel_ctrl_pkg::REG_ADDR_W-1:0] s_awaddr_i,
  input  logic                                  s_awvalid_i,
  output logic                                  s_awready_o,
  input  cipher_pkg::word_t                     s_wdata_i,
  input  logic                                  s_wvalid_i,
  output logic                                  s_wready_o,
  output logic                                  s_bvalid_o,
  input  logic                                  s_bready_i,
  input  logic [accel_ctrl_pkg::REG_ADDR_W-1:0] s_araddr_i,
  input  logic                                  s_arvalid_i,
  output logic                                  s_arready_o,
  output cipher_pkg::word_t                     s_rdata_o,
  output logic                                  s_rvalid_o,
  input  logic                                  s_rready_i,
  output logic                                  mem_req_o,
  output logic                                  mem_we_o,
  output logic [accel_ctrl_pkg::ADDR_W-1:0]     mem_addr_o,
  output cipher_pkg::word_t                     mem_wdata_o,
  input  logic                                  mem_gnt_i,
  input  logic                                  mem_rvalid_i,
  input  cipher_pkg::word_t                     mem_rdata_i,
  output logic                                  done_o
);
  import accel_ctrl_pkg::*;
  import cipher_pkg::*;

  logic              start;
  logic              busy;
  logic              engine_start;
  logic              engine_done;
  logic [ADDR_W-1:0] src_addr;
  logic [ADDR_W-1:0] dst_addr;
  key_t              cfg_key;
  key_t              engine_key;
  block_u            engine_block;
  block_u            engine_result;

  mem_stream_if stream ();

  accel_regfile u_regfile (
    .clk         (clk),
    .reset_n     (reset_n),
    .s_awaddr_i  (s_awaddr_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_araddr_i  (s_araddr_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_rdata_o   (s_rdata_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i),
    .busy_i      (busy),
    .job_done_i  (done_o),
    .start_o     (start),
    .src_addr_o  (src_addr),
    .dst_addr_o  (dst_addr),
    .key_o       (cfg_key)
  );

  block_fsm u_fsm (
    .clk            (clk),
    .reset_n        (reset_n),
    .start_i        (start),
    .src_addr_i     (src_addr),
    .dst_addr_i     (dst_addr),
    .key_i          (cfg_key),
    .busy_o         (busy),
    .job_done_o     (done_o),
    .stream         (stream.ctrl),
    .engine_start_o (engine_start),
    .block_o        (engine_block),
    .key_o          (engine_key),
    .engine_done_i  (engine_done),
    .result_i       (engine_result)
  );

  word_streamer u_streamer (
    .clk          (clk),
    .reset_n      (reset_n),
    .stream       (stream.streamer),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i)
  );

  xtea_engine u_engine (
    .clk      (clk),
    .reset_n  (reset_n),
    .start_i  (engine_start),
    .block_i  (engine_block),
    .key_i    (engine_key),
    .done_o   (engine_done),
    .result_o (engine_result)
  );

endmodule

/* hw/xtea_engine.sv */
`timescale 1ns/10ps

module xtea_engine (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               start_i,
  input  cipher_pkg::block_u block_i,
  input  cipher_pkg::key_t   key_i,
  output logic               done_o,
  output cipher_pkg::block_u result_o
);
  import cipher_pkg::*;

  localparam int RND_W = $clog2(XTEA_ROUNDS);

  block_u           lanes_q, lanes_d;
  key_t             key_q;
  word_t            sum_q, sum_next;
  logic [RND_W-1:0] round_q;
  logic             running_q;

  // XTEA mixing term
  function automatic word_t mix(input word_t v);
    return ((v << 4) ^ (v >> 5)) + v;
  endfunction

  assign sum_next = sum_q + XTEA_DELTA;

  // One full cycle on both lanes, second half-step uses the updated v0
  always_comb begin
    word_t v0;
    word_t v1;
    lanes_d = lanes_q;
    for (int l = 0; l < 2; l++) begin
      v0 = lanes_q.halves[l][31:0];
      v1 = lanes_q.halves[l][63:32];
      v0 = v0 + (mix(v1) ^ (sum_q + key_q[sum_q[1:0]]));
      v1 = v1 + (mix(v0) ^ (sum_next + key_q[sum_next[12:11]]));
      lanes_d.halves[l] = {v1, v0};
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      running_q <= 1'b0;
      round_q   <= '0;
      done_o    <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        running_q <= 1'b1;
        round_q   <= '0;
      end else if (running_q) begin
        round_q <= round_q + 1'b1;
        // Last cycle, result is in lanes_q with done
        if (round_q == RND_W'(XTEA_ROUNDS - 1)) begin
          running_q <= 1'b0;
          done_o    <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      lanes_q <= block_i;
      key_q   <= key_i;
      sum_q   <= '0;
    end else if (running_q) begin
      lanes_q <= lanes_d;
      sum_q   <= sum_next;
    end
  end

  assign result_o = lanes_q;

endmodule

/* hw/word_streamer.sv */
`timescale 1ns/10ps

module word_streamer (
  input  logic                              clk,
  input  logic                              reset_n,
  mem_stream_if.streamer                    stream,
  output logic                              mem_req_o,
  output logic                              mem_we_o,
  output logic [accel_ctrl_pkg::ADDR_W-1:0] mem_addr_o,
  output cipher_pkg::word_t                 mem_wdata_o,
  input  logic                              mem_gnt_i,
  input  logic                              mem_rvalid_i,
  input  cipher_pkg::word_t                 mem_rdata_i
);

  typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_RESP} st_t;

  st_t state_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q     <= ST_IDLE;
      stream.done <= 1'b0;
    end else begin
      stream.done <= 1'b0;
      case (state_q)
        ST_IDLE: if (stream.start) state_q <= ST_REQ;
        ST_REQ: begin
          if (mem_gnt_i) begin
            // Writes finish on grant, reads wait for rvalid
            state_q     <= mem_we_o ? ST_IDLE : ST_RESP;
            stream.done <= mem_we_o;
          end
        end
        ST_RESP: begin
          if (mem_rvalid_i) begin
            state_q     <= ST_IDLE;
            stream.done <= 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request payload held until grant
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && stream.start) begin
      mem_we_o    <= stream.write;
      mem_addr_o  <= stream.addr;
      mem_wdata_o <= stream.wdata;
    end
    if (state_q == ST_RESP && mem_rvalid_i)
      stream.rdata <= mem_rdata_i;
  end

  assign mem_req_o    = (state_q == ST_REQ);
  assign stream.ready = (state_q == ST_IDLE);

endmodule

/* hw/block_fsm.sv */
`timescale 1ns/10ps

module block_fsm (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic                              start_i,
  input  logic [accel_ctrl_pkg::ADDR_W-1:0] src_addr_i,
  input  logic [accel_ctrl_pkg::ADDR_W-1:0] dst_addr_i,
  input  cipher_pkg::key_t                  key_i,
  output logic                              busy_o,
  output logic                              job_done_o,
  mem_stream_if.ctrl                        stream,
  output logic                              engine_start_o,
  output cipher_pkg::block_u                block_o,
  output cipher_pkg::key_t                  key_o,
  input  logic                              engine_done_i,
  input  cipher_pkg::block_u                result_i
);
  import accel_ctrl_pkg::*;
  import cipher_pkg::*;

  localparam int CNT_W = $clog2(BLOCK_WORDS);

  fsm_state_t        state_q, state_d;
  logic [CNT_W-1:0]  word_cnt_q;
  logic              last_word;
  logic [ADDR_W-1:0] src_q, dst_q;
  block_u            block_q;
  key_t              key_q;

  assign last_word = (word_cnt_q == CNT_W'(BLOCK_WORDS - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:        if (start_i) state_d = LOAD;
      LOAD:        if (stream.ready) state_d = LOAD_WAIT;
      LOAD_WAIT:   if (stream.done) state_d = last_word ? CIPHER : LOAD;
      CIPHER:      state_d = CIPHER_WAIT;
      CIPHER_WAIT: if (engine_done_i) state_d = STORE;
      STORE:       if (stream.ready) state_d = STORE_WAIT;
      STORE_WAIT:  if (stream.done) state_d = last_word ? FINISH : STORE;
      FINISH:      state_d = IDLE;
      default:     state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q    <= IDLE;
      word_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      // Counter wraps after the fourth word of each phase
      if (state_q == IDLE || state_q == CIPHER)
        word_cnt_q <= '0;
      else if (stream.done)
        word_cnt_q <= word_cnt_q + 1'b1;
    end
  end

  // Job snapshot and block assembly
  always_ff @(posedge clk) begin
    if (state_q == IDLE && start_i) begin
      src_q <= src_addr_i;
      dst_q <= dst_addr_i;
      key_q <= key_i;
    end
    if (state_q == LOAD_WAIT && stream.done)
      block_q.words[word_cnt_q] <= stream.rdata;
    if (state_q == CIPHER_WAIT && engine_done_i)
      block_q <= result_i;
  end

  assign busy_o         = (state_q != IDLE);
  assign job_done_o     = (state_q == FINISH);
  assign engine_start_o = (state_q == CIPHER);
  assign block_o        = block_q;
  assign key_o          = key_q;

  // Word address is base plus four times the counter
  assign stream.start = (state_q == LOAD || state_q == STORE) && stream.ready;
  assign stream.write = (state_q == STORE);
  assign stream.addr  = (stream.write ? dst_q : src_q)
                        + {{(ADDR_W-CNT_W-2){1'b0}}, word_cnt_q, 2'b00};
  assign stream.wdata = block_q.words[word_cnt_q];

endmodule

/* hw/accel_regfile.sv */
`timescale 1ns/10ps

module accel_regfile (
  input  logic                                clk,
  input  logic                                reset_n,
  input  logic [accel_ctrl_pkg::REG_ADDR_W-1:0] s_awaddr_i,
  input  logic                                s_awvalid_i,
  output logic                                s_awready_o,
  input  cipher_pkg::word_t                   s_wdata_i,
  input  logic                                s_wvalid_i,
  output logic                                s_wready_o,
  output logic                                s_bvalid_o,
  input  logic                                s_bready_i,
  input  logic [accel_ctrl_pkg::REG_ADDR_W-1:0] s_araddr_i,
  input  logic                                s_arvalid_i,
  output logic                                s_arready_o,
  output cipher_pkg::word_t                   s_rdata_o,
  output logic                                s_rvalid_o,
  input  logic                                s_rready_i,
  input  logic                                busy_i,
  input  logic                                job_done_i,
  output logic                                start_o,
  output logic [accel_ctrl_pkg::ADDR_W-1:0]   src_addr_o,
  output logic [accel_ctrl_pkg::ADDR_W-1:0]   dst_addr_o,
  output cipher_pkg::key_t                    key_o
);
  import accel_ctrl_pkg::*;
  import cipher_pkg::*;

  logic  wr_fire;
  logic  rd_fire;
  logic  start_req;
  logic  done_q;
  word_t rd_word;

  // Write takes AW and W together, one at a time
  assign wr_fire     = s_awvalid_i && s_wvalid_i && !s_bvalid_o;
  assign s_awready_o = wr_fire;
  assign s_wready_o  = wr_fire;

  assign s_arready_o = !s_rvalid_o;
  assign rd_fire     = s_arvalid_i && s_arready_o;

  // Start pulse already in flight counts as busy too
  assign start_req = wr_fire && (s_awaddr_i == REG_CTRL) && s_wdata_i[0]
                     && !busy_i && !start_o;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      s_bvalid_o <= 1'b0;
      s_rvalid_o <= 1'b0;
      start_o    <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      start_o <= start_req;
      if (wr_fire)
        s_bvalid_o <= 1'b1;
      else if (s_bready_i)
        s_bvalid_o <= 1'b0;
      if (rd_fire)
        s_rvalid_o <= 1'b1;
      else if (s_rready_i)
        s_rvalid_o <= 1'b0;
      // Sticky done, cleared by the next accepted start
      if (start_req)
        done_q <= 1'b0;
      else if (job_done_i)
        done_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      case (s_awaddr_i)
        REG_SRC:  src_addr_o <= s_wdata_i;
        REG_DST:  dst_addr_o <= s_wdata_i;
        REG_KEY0: key_o[0]   <= s_wdata_i;
        REG_KEY1: key_o[1]   <= s_wdata_i;
        REG_KEY2: key_o[2]   <= s_wdata_i;
        REG_KEY3: key_o[3]   <= s_wdata_i;
        default:  ;
      endcase
    end
    if (rd_fire)
      s_rdata_o <= rd_word;
  end

  // Read decode, CTRL and holes read zero
  always_comb begin
    case (s_araddr_i)
      REG_STATUS: rd_word = {30'd0, done_q, busy_i | start_o};
      REG_SRC:    rd_word = src_addr_o;
      REG_DST:    rd_word = dst_addr_o;
      REG_KEY0:   rd_word = key_o[0];
      REG_KEY1:   rd_word = key_o[1];
      REG_KEY2:   rd_word = key_o[2];
      REG_KEY3:   rd_word = key_o[3];
      default:    rd_word = '0;
    endcase
  end

endmodule

/* hw/mem_stream_if.sv */
`timescale 1ns/10ps

interface mem_stream_if;
  import accel_ctrl_pkg::*;
  import cipher_pkg::*;

  // Transfer request from the sequencer
  logic              start;
  logic              write;
  logic [ADDR_W-1:0] addr;
  word_t             wdata;

  // Streamer side, rdata is valid with done on reads
  logic              ready;
  word_t             rdata;
  logic              done;

  modport ctrl (
    output start, write, addr, wdata,
    input  ready, rdata, done
  );

  modport streamer (
    input  start, write, addr, wdata,
    output ready, rdata, done
  );

endinterface

/* hw/accel_ctrl_pkg.sv */
package accel_ctrl_pkg;

  // Memory side address width
  localparam int ADDR_W = 32;

  // Host side register address width
  localparam int REG_ADDR_W = 5;

  // Register map
  localparam logic [REG_ADDR_W-1:0] REG_CTRL   = 5'h00;
  localparam logic [REG_ADDR_W-1:0] REG_STATUS = 5'h04;
  localparam logic [REG_ADDR_W-1:0] REG_SRC    = 5'h08;
  localparam logic [REG_ADDR_W-1:0] REG_DST    = 5'h0C;
  localparam logic [REG_ADDR_W-1:0] REG_KEY0   = 5'h10;
  localparam logic [REG_ADDR_W-1:0] REG_KEY1   = 5'h14;
  localparam logic [REG_ADDR_W-1:0] REG_KEY2   = 5'h18;
  localparam logic [REG_ADDR_W-1:0] REG_KEY3   = 5'h1C;

  // Job sequencer states
  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    LOAD_WAIT,
    CIPHER,
    CIPHER_WAIT,
    STORE,
    STORE_WAIT,
    FINISH
  } fsm_state_t;

endpackage

/* hw/cipher_pkg.sv */
package cipher_pkg;

  // One memory word
  typedef logic [31:0] word_t;

  // Cycles of the XTEA core, one full Feistel cycle each
  localparam int XTEA_ROUNDS = 32;

  // Key-schedule constant
  localparam word_t XTEA_DELTA = 32'h9E37_79B9;

  // Words per cipher block
  localparam int BLOCK_WORDS = 4;

  // Key words, index 0 is KEY0
  typedef word_t [3:0] key_t;

  // A block is read from memory as four words and ciphered as two
  // 64-bit lanes. Lane 0 holds words 0 and 1, lane 1 holds words 2 and 3.
  // Inside a lane the lower word is v0 and the upper word is v1.
  typedef union packed {
    word_t [BLOCK_WORDS-1:0] words;
    logic [1:0][63:0]        halves;
  } block_u;

endpackage
